//--- files.f
hdl/dcache_pkg.sv
hdl/dcache_if.sv
hdl/dcache_req_stage.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_miss_ctrl.sv
hdl/dcache_top.sv
bench/mem_model.sv
bench/dcache_sva.sv
bench/tb_dcache.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_dcache"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_dcache -Mdir obj_dir -f files.f
	./obj_dir/Vtb_dcache

clean:
	rm -rf obj_dir

//--- bench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

	localparam int N_REQ      = 16;
	localparam int TIMEOUT_NS = (SET_COUNT + 8 + 200 * N_REQ) * 8;

	logic        i_clk;
	logic        i_rst;
	logic        req_valid;
	logic [31:0] addr;
	logic [3:0]  wen;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        valid;
	logic        stall;
	logic        mem_rd_req;
	logic [31:0] mem_rd_addr;
	logic        mem_rd_valid;
	logic [31:0] mem_rd_data;
	logic        mem_wr_valid;
	logic [31:0] mem_wr_addr;
	logic [31:0] mem_wr_data;

	// shadow memory as the program sees it plus per-set tags and tree
	logic [31:0]         shadow [logic [31:0]];
	logic [TAG_BITS-1:0] ref_tag [SET_COUNT][NUM_WAYS];
	logic                ref_valid [SET_COUNT][NUM_WAYS];
	logic [2:0]          ref_tree [SET_COUNT];
	logic                exp_hit;
	logic [31:0]         exp_rdata;
	logic [31:0]         exp_line;
	logic [31:0]         wb_base;
	logic [31:0]         wb_line [LINE_WORDS];
	int unsigned         wb_seen;
	int unsigned         wb_start;
	logic [2:0]          wb_k;
	logic                accepted;
	int                  sweep_cycles;

	dcache_top dut (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_req_valid    (req_valid),
		.i_addr         (addr),
		.i_wen          (wen),
		.i_wdata        (wdata),
		.o_rdata        (rdata),
		.o_valid        (valid),
		.o_stall        (stall),
		.o_mem_rd_req   (mem_rd_req),
		.o_mem_rd_addr  (mem_rd_addr),
		.i_mem_rd_valid (mem_rd_valid),
		.i_mem_rd_data  (mem_rd_data),
		.o_mem_wr_valid (mem_wr_valid),
		.o_mem_wr_addr  (mem_wr_addr),
		.o_mem_wr_data  (mem_wr_data)
	);

	mem_model u_mem (
		.i_clk      (i_clk),
		.i_rd_req   (mem_rd_req),
		.i_rd_addr  (mem_rd_addr),
		.o_rd_valid (mem_rd_valid),
		.o_rd_data  (mem_rd_data),
		.i_wr_valid (mem_wr_valid),
		.i_wr_addr  (mem_wr_addr),
		.i_wr_data  (mem_wr_data)
	);

	initial i_clk = 1'b0;
	always #4 i_clk = ~i_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] read_shadow(input logic [31:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return xorshift(a ^ 32'h9e3779b9);
	endfunction

	// evict the older way of the pair not used last
	function automatic int pick_victim(input logic [2:0] t);
		if (!t[1])
			return t[2] ? 2 : 3;
		return t[0] ? 0 : 1;
	endfunction

	function automatic logic [2:0] tree_touch(input logic [2:0] t, input int w);
		logic [2:0] n;
		n = t;
		case (w)
			0: n = {t[2], 1'b0, 1'b0};
			1: n = {t[2], 1'b0, 1'b1};
			2: n = {1'b0, 1'b1, t[0]};
			default: n = {1'b1, 1'b1, t[0]};
		endcase
		return n;
	endfunction

	function automatic logic [31:0] make_addr(input int tag, input int set, input int off);
		return {TAG_BITS'(tag), INDEX_BITS'(set), OFFSET_BITS'(off), 2'b00};
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expv);
		stop_with_failure($sformatf("MISMATCH %s got %h expected %h", name, got, expv));
	endtask

	// drive one request after updating the reference and wait for its response
	task automatic access(input logic [31:0] a_raw, input logic [3:0] be,
		input logic [31:0] data);
		dcache_addr_u a;
		int           hw;
		int           vw;
		logic [31:0]  waddr;
		logic [31:0]  word;
		a.raw = a_raw;
		hw    = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[a.f.index][w] && ref_tag[a.f.index][w] == a.f.tag)
				hw = w;
		end
		@(posedge i_clk);
		#1;
		exp_hit = hw >= 0;
		if (hw < 0) begin
			vw = pick_victim(ref_tree[a.f.index]);
			if (ref_valid[a.f.index][vw]) begin
				wb_base = {ref_tag[a.f.index][vw], a.f.index, 5'b0};
				for (int k = 0; k < LINE_WORDS; k++)
					wb_line[k] = read_shadow(wb_base + 32'(4 * k));
			end
			ref_tag[a.f.index][vw]   = a.f.tag;
			ref_valid[a.f.index][vw] = 1'b1;
			hw = vw;
		end
		ref_tree[a.f.index] = tree_touch(ref_tree[a.f.index], hw);
		exp_line  = {a.f.tag, a.f.index, 5'b0};
		wb_start  = wb_seen;
		waddr     = {a_raw[31:2], 2'b00};
		word      = read_shadow(waddr);
		exp_rdata = word;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				word[8*b +: 8] = data[8*b +: 8];
		end
		shadow[waddr] = word;
		req_valid = 1'b1;
		addr      = a_raw;
		wen       = be;
		wdata     = data;
		@(negedge i_clk);
		while (stall)
			@(negedge i_clk);
		@(posedge i_clk);
		#1;
		req_valid = 1'b0;
		wen       = '0;
		@(negedge i_clk);
		while (!valid)
			@(negedge i_clk);
	endtask

	assign accepted = req_valid && !stall && !i_rst;
	assign wb_k     = 3'(wb_seen - wb_start);

	always_ff @(posedge i_clk) begin
		if (i_rst)
			wb_seen <= 0;
		else if (mem_wr_valid)
			wb_seen <= wb_seen + 1;
	end

	a_rdata: assert property (@(posedge i_clk) disable iff (i_rst)
		valid |-> rdata == exp_rdata)
		else report_mismatch("o_rdata", $sampled(rdata), exp_rdata);

	a_hit_time: assert property (@(posedge i_clk) disable iff (i_rst)
		accepted && exp_hit |=> valid && !mem_rd_req)
		else stop_with_failure("hit did not respond one cycle after acceptance");

	a_miss_stall: assert property (@(posedge i_clk) disable iff (i_rst)
		accepted && !exp_hit |=> stall && !valid)
		else stop_with_failure("miss did not stall the cache");

	a_rd_addr: assert property (@(posedge i_clk) disable iff (i_rst)
		mem_rd_req |-> mem_rd_addr == exp_line)
		else report_mismatch("o_mem_rd_addr", $sampled(mem_rd_addr), exp_line);

	a_wb_addr: assert property (@(posedge i_clk) disable iff (i_rst)
		mem_wr_valid |-> mem_wr_addr == wb_base + {27'd0, wb_k, 2'b00})
		else report_mismatch("o_mem_wr_addr", $sampled(mem_wr_addr),
			wb_base + {27'd0, $sampled(wb_k), 2'b00});

	a_wb_data: assert property (@(posedge i_clk) disable iff (i_rst)
		mem_wr_valid |-> mem_wr_data == wb_line[wb_k])
		else report_mismatch("o_mem_wr_data", $sampled(mem_wr_data),
			wb_line[$sampled(wb_k)]);

	initial begin
		#(TIMEOUT_NS);
		stop_with_failure("watchdog expired before the tests finished");
	end

	initial begin
		i_rst     = 1'b1;
		req_valid = 1'b0;
		addr      = '0;
		wen       = '0;
		wdata     = '0;
		exp_hit   = 1'b0;
		exp_rdata = '0;
		exp_line  = '0;
		wb_base   = '0;
		wb_start  = 0;
		for (int k = 0; k < LINE_WORDS; k++)
			wb_line[k] = '0;
		for (int s = 0; s < SET_COUNT; s++) begin
			ref_tree[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w]   = '0;
			end
		end
		repeat (8) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		// stall must cover exactly the sweep
		sweep_cycles = 0;
		@(negedge i_clk);
		while (stall) begin
			sweep_cycles++;
			@(negedge i_clk);
		end
		assert (sweep_cycles == SET_COUNT)
			else stop_with_failure("stall length after reset differs from the sweep length");

		access(make_addr(1, 5, 2), 4'b0000, 32'h0);
		access(make_addr(1, 5, 3), 4'b0000, 32'h0);
		access(make_addr(1, 5, 3), 4'b0011, 32'h1111_2222);
		access(make_addr(1, 5, 3), 4'b0000, 32'h0);
		// write miss is allocated then merged on replay
		access(make_addr(2, 5, 0), 4'b1100, 32'hdead_beef);
		access(make_addr(2, 5, 0), 4'b0000, 32'h0);
		access(make_addr(3, 5, 7), 4'b0001, 32'h0000_00a5);
		access(make_addr(4, 5, 1), 4'b0000, 32'h0);
		// with the set full the fifth tag evicts the written line of tag 1
		access(make_addr(5, 5, 4), 4'b0000, 32'h0);
		access(make_addr(1, 5, 3), 4'b0000, 32'h0);
		access(make_addr(6, 5, 6), 4'b1111, 32'h0bad_f00d);
		access(make_addr(2, 5, 0), 4'b0000, 32'h0);
		access(make_addr(3, 5, 7), 4'b0000, 32'h0);
		access(make_addr(7, 9, 2), 4'b0000, 32'h0);
		access(make_addr(7, 9, 2), 4'b0110, 32'h00c3_3c00);
		access(make_addr(7, 9, 2), 4'b0000, 32'h0);

		repeat (4) @(posedge i_clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva import dcache_pkg::*; (
	input logic        i_clk,
	input logic        i_rst,
	input ctrl_state_e i_state,
	input logic        i_rd_req,
	input logic        i_wr_valid
);

	a_rd_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		i_rd_req |=> !i_rd_req)
		else $error("memory read request longer than one cycle");

	// write-back is one unbroken burst of a full line
	a_wb_burst: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(i_wr_valid) |-> i_wr_valid [*LINE_WORDS] ##1 !i_wr_valid)
		else $error("write-back burst is not a full contiguous line");

	a_sweep_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
		i_state == SWEEP |-> !i_rd_req && !i_wr_valid)
		else $error("memory access during the invalidation sweep");

endmodule

bind dcache_miss_ctrl dcache_sva u_sva (
	.i_clk      (i_clk),
	.i_rst      (i_rst),
	.i_state    (state_q),
	.i_rd_req   (o_mem_rd_req),
	.i_wr_valid (o_mem_wr_valid)
);

`default_nettype wire

//--- bench/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model import dcache_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rd_req,
	input  logic [31:0] i_rd_addr,
	output logic        o_rd_valid,
	output logic [31:0] o_rd_data,
	input  logic        i_wr_valid,
	input  logic [31:0] i_wr_addr,
	input  logic [31:0] i_wr_data
);

	logic [31:0] store [logic [31:0]];
	logic [31:0] rng;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// untouched words come from a pattern over the full address
	function automatic logic [31:0] word_at(input logic [31:0] a);
		if (store.exists(a))
			return store[a];
		return xorshift(a ^ 32'h9e3779b9);
	endfunction

	// refill bursts with a short start delay and random holes
	initial begin
		logic [31:0] line;
		int          gap;
		rng        = 32'hafdf29f9;
		o_rd_valid = 1'b0;
		o_rd_data  = '0;
		forever begin
			@(negedge i_clk);
			if (i_rd_req) begin
				line = i_rd_addr;
				rng  = xorshift(rng);
				gap  = 1 + int'(rng % 3);
				repeat (gap - 1) @(posedge i_clk);
				for (int k = 0; k < LINE_WORDS; k++) begin
					rng = xorshift(rng);
					if (k > 0 && rng[0]) begin
						@(posedge i_clk);
						#1;
						o_rd_valid = 1'b0;
					end
					@(posedge i_clk);
					#1;
					o_rd_valid = 1'b1;
					o_rd_data  = word_at(line + 32'(4 * k));
				end
				@(posedge i_clk);
				#1;
				o_rd_valid = 1'b0;
			end
		end
	end

	// write-back words land in storage
	always @(negedge i_clk) begin
		if (i_wr_valid)
			store[i_wr_addr] = i_wr_data;
	end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_req_valid,
	input  logic [31:0] i_addr,
	input  logic [3:0]  i_wen,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_valid,
	output logic        o_stall,
	output logic        o_mem_rd_req,
	output logic [31:0] o_mem_rd_addr,
	input  logic        i_mem_rd_valid,
	input  logic [31:0] i_mem_rd_data,
	output logic        o_mem_wr_valid,
	output logic [31:0] o_mem_wr_addr,
	output logic [31:0] o_mem_wr_data
);

	logic        busy;
	logic [31:0] evict_data;

	lookup_if u_lookup ();
	way_if    u_way ();
	fill_if   u_fill ();

	dcache_req_stage u_req_stage (
		.i_clk,
		.i_rst,
		.i_req_valid,
		.i_addr,
		.i_wen,
		.i_wdata,
		.i_stall (o_stall),
		.i_busy  (busy),
		.lookup  (u_lookup.req)
	);

	dcache_tag_store u_tag_store (
		.i_clk,
		.i_rst,
		.lookup (u_lookup.store),
		.fill   (u_fill.store),
		.way    (u_way.tags)
	);

	dcache_data_store u_data_store (
		.i_clk,
		.lookup       (u_lookup.store),
		.fill         (u_fill.store),
		.way          (u_way.user),
		.o_rdata,
		.o_valid,
		.o_evict_data (evict_data)
	);

	dcache_miss_ctrl u_miss_ctrl (
		.i_clk,
		.i_rst,
		.way          (u_way.user),
		.fill         (u_fill.ctrl),
		.i_evict_data (evict_data),
		.o_stall,
		.o_busy       (busy),
		.o_mem_rd_req,
		.o_mem_rd_addr,
		.i_mem_rd_valid,
		.i_mem_rd_data,
		.o_mem_wr_valid,
		.o_mem_wr_addr,
		.o_mem_wr_data
	);

endmodule

`default_nettype wire

//--- hdl/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl import dcache_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	way_if.user         way,
	fill_if.ctrl        fill,
	input  logic [31:0] i_evict_data,
	output logic        o_stall,
	output logic        o_busy,
	output logic        o_mem_rd_req,
	output logic [31:0] o_mem_rd_addr,
	input  logic        i_mem_rd_valid,
	input  logic [31:0] i_mem_rd_data,
	output logic        o_mem_wr_valid,
	output logic [31:0] o_mem_wr_addr,
	output logic [31:0] o_mem_wr_data
);

	ctrl_state_e            state_q;
	ctrl_state_e            state_d;
	logic [INDEX_BITS-1:0]  sweep_idx;
	logic [OFFSET_BITS:0]   word_cnt;
	logic                   busy_q;
	logic                   rd_req_q;
	logic                   wr_valid_q;
	logic [OFFSET_BITS-1:0] wr_off_q;
	dcache_addr_u           miss_addr_q;
	way_t                   victim_way_q;
	logic [TAG_BITS-1:0]    victim_tag_q;
	logic                   sweeping;
	logic                   evict_rd;
	logic                   evict_done;
	logic                   beat;
	logic                   last_beat;

	assign sweeping   = state_q == SWEEP;
	// eight read cycles and one more to drain the last word
	assign evict_rd   = state_q == EVICT && !word_cnt[OFFSET_BITS];
	assign evict_done = state_q == EVICT && word_cnt[OFFSET_BITS];
	assign beat       = state_q == FETCH && i_mem_rd_valid;
	assign last_beat  = beat && word_cnt[OFFSET_BITS-1:0] == OFFSET_BITS'(LINE_WORDS - 1);

	always_comb begin
		state_d = state_q;
		case (state_q)
			SWEEP: begin
				if (sweep_idx == INDEX_BITS'(SET_COUNT - 1))
					state_d = IDLE;
			end
			IDLE: begin
				if (way.miss)
					state_d = way.victim_valid ? EVICT : FETCH;
			end
			EVICT: begin
				if (evict_done)
					state_d = FETCH;
			end
			FETCH: begin
				if (last_beat)
					state_d = REPLAY;
			end
			REPLAY: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q    <= SWEEP;
			busy_q     <= 1'b1;
			sweep_idx  <= '0;
			word_cnt   <= '0;
			rd_req_q   <= 1'b0;
			wr_valid_q <= 1'b0;
		end else begin
			state_q    <= state_d;
			busy_q     <= state_d != IDLE;
			// one request per refill on entry to FETCH
			rd_req_q   <= state_d == FETCH && state_q != FETCH;
			wr_valid_q <= evict_rd;
			if (sweeping)
				sweep_idx <= sweep_idx + 1'b1;
			if (state_d != state_q)
				word_cnt <= '0;
			else if (evict_rd || beat)
				word_cnt <= word_cnt + 1'b1;
		end
	end

	// miss context held through write-back and refill
	always_ff @(posedge i_clk) begin
		if (state_q == IDLE && way.miss) begin
			miss_addr_q  <= way.miss_addr;
			victim_way_q <= way.victim_way;
			victim_tag_q <= way.victim_tag;
		end
		wr_off_q <= word_cnt[OFFSET_BITS-1:0];
	end

	assign o_busy  = busy_q;
	assign o_stall = busy_q || way.miss;

	assign o_mem_rd_req  = rd_req_q;
	assign o_mem_rd_addr = {miss_addr_q.f.tag, miss_addr_q.f.index, {(OFFSET_BITS + 2){1'b0}}};

	// victim word read last cycle goes out now
	assign o_mem_wr_valid = wr_valid_q;
	assign o_mem_wr_addr  = {victim_tag_q, miss_addr_q.f.index, wr_off_q, 2'b00};
	assign o_mem_wr_data  = i_evict_data;

	assign fill.fill_way    = victim_way_q;
	assign fill.fill_index  = sweeping ? sweep_idx : miss_addr_q.f.index;
	assign fill.word_we     = beat;
	assign fill.word_offset = word_cnt[OFFSET_BITS-1:0];
	assign fill.word_data   = i_mem_rd_data;
	// sweep clears a set per cycle and the last beat validates the new line
	assign fill.tag_we      = sweeping || last_beat;
	assign fill.tag_valid   = !sweeping;
	assign fill.tag_value   = sweeping ? '0 : miss_addr_q.f.tag;
	assign fill.evict_rd    = evict_rd;

endmodule

`default_nettype wire

//--- hdl/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store import dcache_pkg::*; (
	input  logic        i_clk,
	lookup_if.store     lookup,
	fill_if.store       fill,
	way_if.user         way,
	output logic [31:0] o_rdata,
	output logic        o_valid,
	output logic [31:0] o_evict_data
);

	localparam int WORD_ADDR_BITS = INDEX_BITS + OFFSET_BITS;
	localparam int WAY_DEPTH      = SET_COUNT * LINE_WORDS;

	logic [WORD_ADDR_BITS-1:0] rd_word;
	logic [WORD_ADDR_BITS-1:0] wr_word;
	logic                      rd_en;
	logic                      hit_write;
	logic [NUM_WAYS-1:0]       wr_en;
	logic [3:0]                wr_be;
	logic [31:0]               wr_data;
	logic [NUM_WAYS-1:0][31:0] way_word;

	// victim words take the read port during write-back
	assign rd_en   = lookup.rd_en || fill.evict_rd;
	assign rd_word = fill.evict_rd ? {fill.fill_index, fill.word_offset}
		: {lookup.rd_addr.f.index, lookup.rd_addr.f.offset};

	// refill beats and write hits never share a cycle
	assign hit_write = way.hit && |lookup.s2_wen;
	assign wr_word   = fill.word_we ? {fill.fill_index, fill.word_offset}
		: {lookup.s2_addr.f.index, lookup.s2_addr.f.offset};
	assign wr_be     = fill.word_we ? 4'b1111 : lookup.s2_wen;
	assign wr_data   = fill.word_we ? fill.word_data : lookup.s2_wdata;

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		logic [31:0] mem [WAY_DEPTH];
		logic [31:0] rd_q;

		assign wr_en[w] = fill.word_we ? fill.fill_way == way_t'(w)
			: hit_write && way.hit_way == way_t'(w);

		always_ff @(posedge i_clk) begin
			if (rd_en) begin
				rd_q <= mem[rd_word];
				// a read of the word being written sees the merged bytes
				if (wr_en[w] && wr_word == rd_word) begin
					for (int b = 0; b < 4; b++) begin
						if (wr_be[b])
							rd_q[8*b +: 8] <= wr_data[8*b +: 8];
					end
				end
			end
			for (int b = 0; b < 4; b++) begin
				if (wr_en[w] && wr_be[b])
					mem[wr_word][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end

		assign way_word[w] = rd_q;
	end

	// old word on a write hit since the merge lands at the edge
	assign o_rdata      = way_word[way.hit_way];
	assign o_valid      = way.hit;
	assign o_evict_data = way_word[fill.fill_way];

endmodule

`default_nettype wire

//--- hdl/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store import dcache_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst,
	lookup_if.store lookup,
	fill_if.store   fill,
	way_if.tags     way
);

	logic [NUM_WAYS-1:0][TAG_BITS-1:0] way_tag;
	logic [NUM_WAYS-1:0]               way_valid;
	logic [NUM_WAYS-1:0]               match;
	plru_t                             plru_mem [SET_COUNT];
	plru_t                             plru_cur;
	logic [INDEX_BITS-1:0]             s2_index;
	way_t                              hit_enc;
	way_t                              victim;
	logic                              hit;
	logic                              miss;

	assign s2_index = lookup.s2_addr.f.index;

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		logic [TAG_BITS-1:0] tag_mem   [SET_COUNT];
		logic                valid_mem [SET_COUNT];
		logic [TAG_BITS-1:0] tag_q;
		logic                valid_q;

		always_ff @(posedge i_clk) begin
			if (lookup.rd_en) begin
				tag_q   <= tag_mem[lookup.rd_addr.f.index];
				valid_q <= valid_mem[lookup.rd_addr.f.index];
			end
			// an invalidating write clears the whole set
			if (fill.tag_we && (!fill.tag_valid || fill.fill_way == way_t'(w))) begin
				tag_mem[fill.fill_index]   <= fill.tag_value;
				valid_mem[fill.fill_index] <= fill.tag_valid;
			end
		end

		assign way_tag[w]   = tag_q;
		assign way_valid[w] = valid_q;
		assign match[w]     = valid_q && tag_q == lookup.s2_addr.f.tag;
	end

	always_comb begin
		hit_enc = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (match[w])
				hit_enc = way_t'(w);
		end
	end

	assign plru_cur = plru_mem[s2_index];
	assign victim   = plru_victim(plru_cur);
	assign hit      = lookup.s2_valid && |match;
	assign miss     = lookup.s2_valid && !(|match);

	// the victim counts as used once the miss is taken
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			plru_mem <= '{default: '0};
		end else if (hit) begin
			plru_mem[s2_index] <= plru_touch(plru_cur, hit_enc);
		end else if (miss) begin
			plru_mem[s2_index] <= plru_touch(plru_cur, victim);
		end
	end

	assign way.hit          = hit;
	assign way.hit_way      = hit_enc;
	assign way.miss         = miss;
	assign way.victim_way   = victim;
	assign way.victim_valid = way_valid[victim];
	assign way.victim_tag   = way_tag[victim];
	assign way.miss_addr    = lookup.s2_addr;

endmodule

`default_nettype wire

//--- hdl/dcache_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_stage import dcache_pkg::*; (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic        i_req_valid,
	input  logic [31:0] i_addr,
	input  logic [3:0]  i_wen,
	input  logic [31:0] i_wdata,
	input  logic        i_stall,
	input  logic        i_busy,
	lookup_if.req       lookup
);

	logic         s2_valid_q;
	dcache_addr_u s2_addr_q;
	logic [3:0]   s2_wen_q;
	logic [31:0]  s2_wdata_q;
	dcache_addr_u req_addr;
	logic         accept;

	assign req_addr.raw = i_addr;
	assign accept       = i_req_valid && !i_stall;

	// stage 2 holds its request for as long as the stall lasts
	always_ff @(posedge i_clk) begin
		if (i_rst)
			s2_valid_q <= 1'b0;
		else if (!i_stall)
			s2_valid_q <= i_req_valid;
	end

	always_ff @(posedge i_clk) begin
		if (accept) begin
			s2_addr_q  <= req_addr;
			s2_wen_q   <= i_wen;
			s2_wdata_q <= i_wdata;
		end
	end

	// re-read the held set during a stall so replay sees the refilled line
	assign lookup.rd_en   = i_req_valid || i_stall;
	assign lookup.rd_addr = i_stall ? s2_addr_q : req_addr;

	// nothing is compared while a miss sequence runs
	assign lookup.s2_valid = s2_valid_q && !i_busy;
	assign lookup.s2_addr  = s2_addr_q;
	assign lookup.s2_wen   = s2_wen_q;
	assign lookup.s2_wdata = s2_wdata_q;

endmodule

`default_nettype wire

//--- hdl/dcache_if.sv
`timescale 1ns/1ps
`default_nettype none

// request address and the request sitting in the compare stage
interface lookup_if import dcache_pkg::*; ();
	logic         rd_en;
	dcache_addr_u rd_addr;
	logic         s2_valid;
	dcache_addr_u s2_addr;
	logic [3:0]   s2_wen;
	logic [31:0]  s2_wdata;

	modport req (output rd_en, rd_addr, s2_valid, s2_addr, s2_wen, s2_wdata);
	modport store (input rd_en, rd_addr, s2_valid, s2_addr, s2_wen, s2_wdata);
endinterface

// compare result and replacement choice
interface way_if import dcache_pkg::*; ();
	logic                hit;
	way_t                hit_way;
	logic                miss;
	way_t                victim_way;
	logic                victim_valid;
	logic [TAG_BITS-1:0] victim_tag;
	// address of the request that missed
	dcache_addr_u        miss_addr;

	modport tags (output hit, hit_way, miss, victim_way, victim_valid, victim_tag,
		miss_addr);
	modport user (input hit, hit_way, miss, victim_way, victim_valid, victim_tag,
		miss_addr);
endinterface

// array writes and victim reads from the miss controller
interface fill_if import dcache_pkg::*; ();
	way_t                   fill_way;
	logic [INDEX_BITS-1:0]  fill_index;
	logic                   word_we;
	logic [OFFSET_BITS-1:0] word_offset;
	logic [31:0]            word_data;
	logic                   tag_we;
	logic                   tag_valid;
	logic [TAG_BITS-1:0]    tag_value;
	logic                   evict_rd;

	modport ctrl (output fill_way, fill_index, word_we, word_offset, word_data,
		tag_we, tag_valid, tag_value, evict_rd);
	modport store (input fill_way, fill_index, word_we, word_offset, word_data,
		tag_we, tag_valid, tag_value, evict_rd);
endinterface

`default_nettype wire

//--- hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	localparam int NUM_WAYS    = 4;
	localparam int LINE_WORDS  = 8;
	localparam int SET_COUNT   = 128;
	localparam int TAG_BITS    = 20;
	localparam int INDEX_BITS  = 7;
	localparam int OFFSET_BITS = 3;

	// one address word seen raw or split into cache fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [TAG_BITS-1:0]    tag;
			logic [INDEX_BITS-1:0]  index;
			logic [OFFSET_BITS-1:0] offset;
			logic [1:0]             byte_sel;
		} f;
	} dcache_addr_u;

	// bit 1 marks the pair used last and bits 0 and 2 the way used last within each pair
	typedef logic [2:0] plru_t;
	typedef logic [1:0] way_t;

	typedef enum logic [2:0] {
		SWEEP,
		IDLE,
		EVICT,
		FETCH,
		REPLAY
	} ctrl_state_e;

	function automatic plru_t plru_touch(input plru_t state, input way_t way);
		plru_t upd;
		upd    = state;
		upd[1] = way[1];
		if (way[1])
			upd[2] = way[0];
		else
			upd[0] = way[0];
		return upd;
	endfunction

	// way not used last in the pair not used last
	function automatic way_t plru_victim(input plru_t state);
		way_t way;
		if (state[1])
			way = {1'b0, ~state[0]};
		else
			way = {1'b1, ~state[2]};
		return way;
	endfunction

endpackage

`default_nettype wire
